// ==== build.f ====
+incdir+.
shifter_pkg.sv
beam_if.sv
regs_if.sv
shifter_regs.sv
video_timing.sv
plane_fetch.sv
pixel_shifter.sv
shifter_top.sv
tb_shifter.sv

// ==== tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// ------------------------------------------------------------
// random bits
// ------------------------------------------------------------

// 32 bit fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// one lfsr step for every bit taken
function automatic logic [15:0] rand_bits(input int n);
	logic [15:0] v;
	v = '0;
	for (int k = 0; k < n; k++) begin
		lfsr_state = lfsr_next(lfsr_state);
		v = {v[14:0], lfsr_state[0]};
	end
	return v;
endfunction

// ------------------------------------------------------------
// video memory model
// ------------------------------------------------------------

// plane number follows from the word offset to the frame base
function automatic shifter_pkg::word_t mem_word(input shifter_pkg::vaddr_t addr);
	shifter_pkg::vaddr_t off;
	int plane;
	off = addr - mem_base;
	plane = int'(off) % mem_planes;
	// mono uses one constant word everywhere
	if (mem_mono)
		return mono_word;
	return color_k[plane] ? 16'hffff : 16'h0000;
endfunction

// ------------------------------------------------------------
// cpu bus access
// ------------------------------------------------------------

// lanes bit 1 is the upper byte, bit 0 the lower, 1 means enabled
task automatic cpu_write(input logic [5:0] addr, input shifter_pkg::word_t data,
	input logic [1:0] lanes);
	@(posedge clk);
	#1;
	cpu_sel = 1'b1;
	cpu_rw = 1'b0;
	cpu_addr = addr;
	cpu_din = data;
	cpu_uds = !lanes[1];
	cpu_lds = !lanes[0];
	// write lands on this edge only
	@(posedge clk);
	#1;
	cpu_sel = 1'b0;
	cpu_rw = 1'b1;
	cpu_uds = 1'b1;
	cpu_lds = 1'b1;
endtask

// read is combinational, sampled mid cycle
// select stays high until the next access, reads have no side effect
task automatic cpu_read(input logic [5:0] addr, output shifter_pkg::word_t data);
	@(posedge clk);
	#1;
	cpu_sel = 1'b1;
	cpu_rw = 1'b1;
	cpu_addr = addr;
	@(negedge clk);
	data = cpu_dout;
endtask

// ------------------------------------------------------------
// expected values
// ------------------------------------------------------------

// 3 bit channel in the top of the 4 bit output
function automatic logic [11:0] pal_rgb(input shifter_pkg::word_t w);
	return {w[10:8], 1'b0, w[6:4], 1'b0, w[2:0], 1'b0};
endfunction

function automatic int frame_clocks();
	return H_TOTAL * V_TOTAL;
endfunction

function automatic int display_clocks();
	return V_DISP * H_DISP;
endfunction

// everything not blanked
function automatic int visible_clocks();
	return (V_DISP + 2 * V_BORDER) * (H_DISP + 2 * H_BORDER);
endfunction

function automatic int border_clocks();
	return visible_clocks() - display_clocks();
endfunction

// one word per 16 display clocks
function automatic int reads_per_frame();
	return V_DISP * H_DISP / 16;
endfunction

function automatic int ones_in(input shifter_pkg::word_t w);
	int n;
	n = 0;
	for (int k = 0; k < 16; k++)
		n += w[k];
	return n;
endfunction

// display pixels after inversion, border shows the inversion bit
function automatic int mono_ones(input shifter_pkg::word_t d, input logic inv);
	return V_DISP * (H_DISP / 16) * ones_in(d ^ {16{inv}}) + (inv ? border_clocks() : 0);
endfunction

`endif

// ==== tb_shifter.sv ====
`timescale 1ns/1ps

module tb_shifter;

	// small geometry with horizontal values kept at multiples of 64
	localparam int H_DISP   = 128;
	localparam int H_BORDER = 64;
	localparam int H_BLANK  = 64;
	localparam int H_SYNC   = 64;
	localparam int V_DISP   = 8;
	localparam int V_BORDER = 2;
	localparam int V_BLANK  = 1;
	localparam int V_SYNC   = 2;
	localparam int H_TOTAL = H_DISP + 2 * H_BORDER + 2 * H_BLANK + H_SYNC;
	localparam int V_TOTAL = V_DISP + 2 * V_BORDER + 2 * V_BLANK + V_SYNC;
	// sync selectors for the edge helpers
	localparam int SEL_HS = 0;
	localparam int SEL_VS = 1;

	logic clk;
	logic cpu_reset;
	logic cpu_sel;
	logic cpu_rw;
	logic cpu_uds;
	logic cpu_lds;
	logic [5:0] cpu_addr;
	shifter_pkg::word_t cpu_din;
	shifter_pkg::word_t cpu_dout;
	logic read;
	shifter_pkg::vaddr_t mem_addr;
	shifter_pkg::word_t mem_data;
	logic hs;
	logic vs;
	logic [3:0] video_r;
	logic [3:0] video_g;
	logic [3:0] video_b;

	logic [31:0] lfsr_state;
	// memory model state
	shifter_pkg::vaddr_t mem_base;
	bit mem_mono;
	logic [3:0] color_k;
	int mem_planes;
	shifter_pkg::word_t mono_word;
	// reads in flight inside the memory model
	logic [1:0] mem_pend;
	shifter_pkg::vaddr_t mem_pend_addr [2];
	int checks;
	int errors;

	`include "tb_model.svh"

	shifter_top #(
		.H_DISP   (H_DISP),
		.H_BORDER (H_BORDER),
		.H_BLANK  (H_BLANK),
		.H_SYNC   (H_SYNC),
		.V_DISP   (V_DISP),
		.V_BORDER (V_BORDER),
		.V_BLANK  (V_BLANK),
		.V_SYNC   (V_SYNC)
	) DUT (
		.clk       (clk),
		.cpu_reset (cpu_reset),
		.cpu_sel   (cpu_sel),
		.cpu_rw    (cpu_rw),
		.cpu_uds   (cpu_uds),
		.cpu_lds   (cpu_lds),
		.cpu_addr  (cpu_addr),
		.cpu_din   (cpu_din),
		.cpu_dout  (cpu_dout),
		.read      (read),
		.mem_addr  (mem_addr),
		.mem_data  (mem_data),
		.hs        (hs),
		.vs        (vs),
		.video_r   (video_r),
		.video_g   (video_g),
		.video_b   (video_b)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// memory answers at the third edge after a strobe and floats otherwise
	initial begin
		forever begin
			@(posedge clk);
			#1;
			// word is stable only across the edge where fetch samples it
			mem_data = mem_pend[1] ? mem_word(mem_pend_addr[1]) : 'x;
			mem_pend = {mem_pend[0], read};
			mem_pend_addr[1] = mem_pend_addr[0];
			mem_pend_addr[0] = mem_addr;
		end
	end

	// ------------------------------------------------------------
	// reporting
	// ------------------------------------------------------------
	task automatic expect_equal(input string name, input logic [31:0] exp_val,
		input logic [31:0] act_val);
		checks++;
		assert (exp_val === act_val)
		else begin
			errors++;
			$display("** Error %s: expected %0d (0x%0h), actual %0d (0x%0h)",
				name, exp_val, exp_val, act_val, act_val);
		end
	endtask

	task automatic close_run;
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	endtask

	task automatic give_up(input string what);
		errors++;
		$display("timed out waiting for %s", what);
		close_run;
	endtask

	function automatic logic probe(input int sel);
		return (sel == SEL_HS) ? hs : vs;
	endfunction

	// returns on the first low sample after a high one
	task automatic wait_fall(input int sel, input int limit, input string what);
		logic prev;
		bit seen;
		int n;
		prev = 1'b0;
		seen = 0;
		n = 0;
		while (!seen && n < limit) begin
			@(negedge clk);
			seen = prev && !probe(sel);
			prev = probe(sel);
			n++;
		end
		if (!seen)
			give_up(what);
	endtask

	// the current sample is already at level and counting runs until it changes
	task automatic count_run(input int sel, input logic level, input int limit,
		input string what, output int n);
		bit done;
		n = 1;
		done = 0;
		while (!done && n <= limit) begin
			@(negedge clk);
			if (probe(sel) == level)
				n++;
			else
				done = 1;
		end
		if (!done)
			give_up(what);
	endtask

	// ------------------------------------------------------------
	// tests
	// ------------------------------------------------------------
	task automatic register_test;
		shifter_pkg::word_t rd;
		shifter_pkg::word_t wr;
		shifter_pkg::word_t pal_exp [16];
		logic [7:0] hi;
		logic [7:0] mid;
		logic [1:0] lanes;
		// vaddr goes first since fetch starts stepping it a few clocks after reset
		cpu_read(shifter_pkg::REG_VADDR_HI, rd);
		expect_equal("reset vaddr hi", shifter_pkg::BASE_ADDR_RESET[22:15], rd);
		cpu_read(shifter_pkg::REG_VADDR_MID, rd);
		expect_equal("reset vaddr mid", shifter_pkg::BASE_ADDR_RESET[14:7], rd);
		cpu_read(shifter_pkg::REG_VADDR_LO, rd);
		expect_equal("reset vaddr lo", {shifter_pkg::BASE_ADDR_RESET[6:0], 1'b0}, rd);
		cpu_read(shifter_pkg::REG_BASE_HI, rd);
		expect_equal("reset base hi", shifter_pkg::BASE_ADDR_RESET[22:15], rd);
		cpu_read(shifter_pkg::REG_BASE_MID, rd);
		expect_equal("reset base mid", shifter_pkg::BASE_ADDR_RESET[14:7], rd);
		cpu_read(shifter_pkg::REG_SHMODE, rd);
		expect_equal("reset shmode", {6'h00, shifter_pkg::DEFAULT_MODE, 8'h00}, rd);
		for (int e = 0; e < 16; e++) begin
			cpu_read(6'(shifter_pkg::REG_PAL_FIRST + e), rd);
			expect_equal($sformatf("reset palette %0d", e), 0, rd);
		end

		// random base bytes
		hi = 8'(rand_bits(8));
		mid = 8'(rand_bits(8));
		cpu_write(shifter_pkg::REG_BASE_HI, {8'(rand_bits(8)), hi}, 2'b11);
		cpu_write(shifter_pkg::REG_BASE_MID, {8'(rand_bits(8)), mid}, 2'b11);
		cpu_read(shifter_pkg::REG_BASE_HI, rd);
		expect_equal("base hi", {8'h00, hi}, rd);
		cpu_read(shifter_pkg::REG_BASE_MID, rd);
		expect_equal("base mid", {8'h00, mid}, rd);
		// base must hold with the lower lane disabled
		cpu_write(shifter_pkg::REG_BASE_HI, rand_bits(16), 2'b10);
		cpu_read(shifter_pkg::REG_BASE_HI, rd);
		expect_equal("base hi lane", {8'h00, hi}, rd);
		mem_base = {hi, mid, 7'h00};

		// full palette where the top bit of each nibble reads zero
		for (int e = 0; e < 16; e++) begin
			wr = rand_bits(16);
			cpu_write(6'(shifter_pkg::REG_PAL_FIRST + e), wr, 2'b11);
			pal_exp[e] = wr & 16'h0777;
		end
		for (int e = 0; e < 16; e++) begin
			cpu_read(6'(shifter_pkg::REG_PAL_FIRST + e), rd);
			expect_equal($sformatf("palette %0d", e), pal_exp[e], rd);
		end

		// lanes alternate per entry
		for (int e = 0; e < 16; e++) begin
			wr = rand_bits(16);
			lanes = e[0] ? 2'b10 : 2'b01;
			cpu_write(6'(shifter_pkg::REG_PAL_FIRST + e), wr, lanes);
			if (lanes[1])
				pal_exp[e][15:8] = wr[15:8] & 8'h07;
			if (lanes[0])
				pal_exp[e][7:0] = wr[7:0] & 8'h77;
			cpu_read(6'(shifter_pkg::REG_PAL_FIRST + e), rd);
			expect_equal($sformatf("palette %0d lane", e), pal_exp[e], rd);
		end
	endtask

	task automatic verify_sync;
		int lo;
		int hi;
		wait_fall(SEL_HS, 2 * H_TOTAL, "hs falling edge");
		count_run(SEL_HS, 1'b0, 2 * H_TOTAL, "hs rising edge", lo);
		count_run(SEL_HS, 1'b1, 2 * H_TOTAL, "hs falling edge", hi);
		expect_equal("hs low clocks", H_SYNC, lo);
		expect_equal("hs period", H_TOTAL, lo + hi);
		wait_fall(SEL_VS, 2 * frame_clocks(), "vs falling edge");
		count_run(SEL_VS, 1'b0, 2 * frame_clocks(), "vs rising edge", lo);
		expect_equal("vs low clocks", V_SYNC * H_TOTAL, lo);
	endtask

	// new frame base that the dut loads at the next vsync
	task automatic new_base;
		logic [7:0] hi;
		logic [7:0] mid;
		hi = 8'(rand_bits(8));
		mid = 8'(rand_bits(8));
		cpu_write(shifter_pkg::REG_BASE_HI, {8'h00, hi}, 2'b01);
		cpu_write(shifter_pkg::REG_BASE_MID, {8'h00, mid}, 2'b01);
		mem_base = {hi, mid, 7'h00};
	endtask

	// fetch addresses and pixel classes over one frame from a vs fall
	task automatic measure_frame(input string name, input logic [11:0] color_a,
		input logic [11:0] color_b, input int exp_a, input int exp_b);
		int reads;
		int cnt_a;
		int cnt_b;
		int cnt_zero;
		int cnt_other;
		shifter_pkg::vaddr_t last;
		logic [11:0] pix;
		reads = 0;
		cnt_a = 0;
		cnt_b = 0;
		cnt_zero = 0;
		cnt_other = 0;
		last = '0;
		wait_fall(SEL_VS, 2 * frame_clocks(), "vs falling edge");
		for (int c = 0; c < frame_clocks(); c++) begin
			@(negedge clk);
			if (read) begin
				if (reads == 0)
					expect_equal({name, " first address"}, mem_base, mem_addr);
				else
					expect_equal({name, " address step"}, last + 1'b1, mem_addr);
				last = mem_addr;
				reads++;
			end
			pix = {video_r, video_g, video_b};
			if (pix == color_a)
				cnt_a++;
			else if (pix == color_b)
				cnt_b++;
			else if (pix == 12'h000)
				cnt_zero++;
			else
				cnt_other++;
		end
		expect_equal({name, " reads"}, reads_per_frame(), reads);
		expect_equal({name, " main colour clocks"}, exp_a, cnt_a);
		// mono has a single lit colour
		if (color_b != color_a)
			expect_equal({name, " second colour clocks"}, exp_b, cnt_b);
		expect_equal({name, " zero clocks"}, frame_clocks() - exp_a - exp_b, cnt_zero);
		expect_equal({name, " other clocks"}, 0, cnt_other);
	endtask

	task automatic colour_mode(input shifter_pkg::shift_mode_e mode, input int planes,
		input string name);
		shifter_pkg::word_t pal0;
		shifter_pkg::word_t palk;
		logic [3:0] k;
		cpu_write(shifter_pkg::REG_SHMODE, {6'h00, mode, 8'h00}, 2'b11);
		new_base;
		// nonzero index inside the plane count
		k = 4'(1 + rand_bits(planes) % ((1 << planes) - 1));
		do
			pal0 = rand_bits(16) & 16'h0777;
		while (pal0 == '0);
		do
			palk = rand_bits(16) & 16'h0777;
		while (palk == '0 || palk == pal0);
		cpu_write(shifter_pkg::REG_PAL_FIRST, pal0, 2'b11);
		cpu_write(6'(shifter_pkg::REG_PAL_FIRST + k), palk, 2'b11);
		mem_mono = 0;
		color_k = k;
		mem_planes = planes;
		measure_frame(name, pal_rgb(palk), pal_rgb(pal0), display_clocks(),
			border_clocks());
	endtask

	task automatic mono_mode;
		shifter_pkg::word_t d;
		logic inv;
		cpu_write(shifter_pkg::REG_SHMODE, {6'h00, shifter_pkg::MODE_MONO, 8'h00}, 2'b11);
		new_base;
		d = rand_bits(16);
		inv = 1'(rand_bits(1));
		// blue bit 0 of entry 0 is the inversion bit
		cpu_write(shifter_pkg::REG_PAL_FIRST, (rand_bits(16) & 16'h0776) | inv, 2'b11);
		mem_mono = 1;
		mono_word = d;
		mem_planes = 1;
		measure_frame("mono", 12'hfff, 12'hfff, mono_ones(d, inv), 0);
	endtask

	// ------------------------------------------------------------
	// sequence
	// ------------------------------------------------------------
	initial begin
		cpu_reset = 1'b1;
		cpu_sel = 1'b0;
		cpu_rw = 1'b1;
		cpu_uds = 1'b1;
		cpu_lds = 1'b1;
		cpu_addr = '0;
		cpu_din = '0;
		mem_data = '0;
		mem_pend = '0;
		mem_pend_addr[0] = '0;
		mem_pend_addr[1] = '0;
		lfsr_state = 32'd76890;
		mem_base = shifter_pkg::BASE_ADDR_RESET;
		mem_mono = 1;
		color_k = '0;
		mem_planes = 1;
		mono_word = '0;
		checks = 0;
		errors = 0;
		repeat (16) @(posedge clk);
		#1;
		cpu_reset = 1'b0;
		register_test;
		verify_sync;
		colour_mode(shifter_pkg::MODE_LOW, 4, "low");
		colour_mode(shifter_pkg::MODE_MID, 2, "mid");
		mono_mode;
		close_run;
	end

endmodule

// ==== shifter_top.sv ====
`timescale 1ns/1ps

module shifter_top #(
	parameter int H_DISP   = shifter_pkg::DEF_H_DISP,
	parameter int H_BORDER = shifter_pkg::DEF_H_BORDER,
	parameter int H_BLANK  = shifter_pkg::DEF_H_BLANK,
	parameter int H_SYNC   = shifter_pkg::DEF_H_SYNC,
	parameter int V_DISP   = shifter_pkg::DEF_V_DISP,
	parameter int V_BORDER = shifter_pkg::DEF_V_BORDER,
	parameter int V_BLANK  = shifter_pkg::DEF_V_BLANK,
	parameter int V_SYNC   = shifter_pkg::DEF_V_SYNC
) (
	input  logic clk,
	input  logic cpu_reset,

	// cpu register port
	input  logic cpu_sel,
	input  logic cpu_rw,
	input  logic cpu_uds,
	input  logic cpu_lds,
	input  logic [5:0] cpu_addr,
	input  shifter_pkg::word_t cpu_din,
	output shifter_pkg::word_t cpu_dout,

	// video memory port
	output logic read,
	output shifter_pkg::vaddr_t mem_addr,
	input  shifter_pkg::word_t mem_data,

	// screen
	output logic hs,
	output logic vs,
	output logic [3:0] video_r,
	output logic [3:0] video_g,
	output logic [3:0] video_b
);

	beam_if beam ();
	regs_if regs ();

	shifter_pkg::plane_words_t plane_words;

	shifter_regs u_regs (
		.clk       (clk),
		.cpu_reset (cpu_reset),
		.cpu_sel   (cpu_sel),
		.cpu_rw    (cpu_rw),
		.cpu_uds   (cpu_uds),
		.cpu_lds   (cpu_lds),
		.cpu_addr  (cpu_addr),
		.cpu_din   (cpu_din),
		.cpu_dout  (cpu_dout),
		.regs      (regs)
	);

	// geometry only matters to the beam counters
	video_timing #(
		.H_DISP   (H_DISP),
		.H_BORDER (H_BORDER),
		.H_BLANK  (H_BLANK),
		.H_SYNC   (H_SYNC),
		.V_DISP   (V_DISP),
		.V_BORDER (V_BORDER),
		.V_BLANK  (V_BLANK),
		.V_SYNC   (V_SYNC)
	) u_timing (
		.clk       (clk),
		.cpu_reset (cpu_reset),
		.beam      (beam),
		.regs      (regs),
		.hs        (hs),
		.vs        (vs)
	);

	plane_fetch u_fetch (
		.clk         (clk),
		.cpu_reset   (cpu_reset),
		.beam        (beam),
		.regs        (regs),
		.read        (read),
		.mem_addr    (mem_addr),
		.mem_data    (mem_data),
		.plane_words (plane_words)
	);

	pixel_shifter u_pixel (
		.clk         (clk),
		.cpu_reset   (cpu_reset),
		.beam        (beam),
		.regs        (regs),
		.plane_words (plane_words),
		.video_r     (video_r),
		.video_g     (video_g),
		.video_b     (video_b)
	);

endmodule

// ==== pixel_shifter.sv ====
`timescale 1ns/1ps

module pixel_shifter (
	input  logic clk,
	input  logic cpu_reset,
	beam_if.pixel beam,
	regs_if.pixel regs,
	input  shifter_pkg::plane_words_t plane_words,
	output logic [3:0] video_r,
	output logic [3:0] video_g,
	output logic [3:0] video_b
);

	shifter_pkg::plane_words_t shift_q;
	shifter_pkg::rgb_t rgb_q;
	logic [5:0] cnt_q;
	logic [5:0] offset;
	logic [5:0] grp_mask;
	logic [5:0] pix_mask;
	logic [3:0] plane_en;
	logic mono;
	logic mono_bit;
	// beam flags delayed to line up with the shifter output
	logic blank_d;
	logic border_d;

	// ------------------------------------------------------------
	// mode decode
	// ------------------------------------------------------------
	always_comb begin
		// group is 16 pixels, pixel is 1, 2 or 4 clocks
		case (regs.shmode)
			shifter_pkg::MODE_MONO: begin
				grp_mask = 6'h0f;
				pix_mask = 6'h00;
				plane_en = 4'b0001;
			end
			shifter_pkg::MODE_MID: begin
				grp_mask = 6'h1f;
				pix_mask = 6'h01;
				plane_en = 4'b0011;
			end
			default: begin
				grp_mask = 6'h3f;
				pix_mask = 6'h03;
				plane_en = 4'b1111;
			end
		endcase
		// clock offset from the first display clock of the line
		offset = beam.disp_start ? 6'd0 : cnt_q;
	end

	assign mono = (regs.shmode == shifter_pkg::MODE_MONO);

	always_ff @(posedge clk) begin
		if (cpu_reset)
			cnt_q <= '0;
		else
			cnt_q <= offset + 6'd1;
	end

	// ------------------------------------------------------------
	// plane shift registers
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!beam.in_display) begin
			shift_q <= '0;
		end else if ((offset & grp_mask) == 6'd0) begin
			// load on group boundary, planes unused in this mode read as zero
			for (int p = 0; p < shifter_pkg::MAX_PLANES; p++)
				shift_q[p] <= plane_en[p] ? plane_words[p] : '0;
		end else if ((offset & pix_mask) == 6'd0) begin
			for (int p = 0; p < shifter_pkg::MAX_PLANES; p++)
				shift_q[p] <= {shift_q[p][14:0], 1'b0};
		end
	end

	// ------------------------------------------------------------
	// colour index, palette and output register
	// ------------------------------------------------------------

	// border and mono always use entry 0
	assign regs.pal_index = (mono || border_d) ? 4'd0 :
		{shift_q[3][15], shift_q[2][15], shift_q[1][15], shift_q[0][15]};

	// blue bit 0 of entry 0 inverts mono video
	assign mono_bit = shift_q[0][15] ^ regs.pal_color.b[0];

	always_ff @(posedge clk) begin
		if (cpu_reset) begin
			blank_d <= 1'b1;
			border_d <= 1'b0;
			rgb_q <= '0;
		end else begin
			blank_d <= beam.blank;
			border_d <= beam.border;
			if (blank_d)
				rgb_q <= '0;
			else if (mono)
				rgb_q <= {{4{mono_bit}}, {4{mono_bit}}, {4{mono_bit}}};
			else
				rgb_q <= {regs.pal_color.r, 1'b0, regs.pal_color.g, 1'b0,
					regs.pal_color.b, 1'b0};
		end
	end

	assign video_r = rgb_q.r;
	assign video_g = rgb_q.g;
	assign video_b = rgb_q.b;

endmodule

// ==== plane_fetch.sv ====
`timescale 1ns/1ps

module plane_fetch (
	input  logic clk,
	input  logic cpu_reset,
	beam_if.fetch beam,
	regs_if.fetch regs,
	output logic read,
	output shifter_pkg::vaddr_t mem_addr,
	input  shifter_pkg::word_t mem_data,
	output shifter_pkg::plane_words_t plane_words
);

	shifter_pkg::vaddr_t vaddr_q;
	logic [1:0] plane_q;
	logic [1:0] last_plane;
	logic [1:0] rd_pipe;
	logic fetch_en_q;
	logic sample;

	// highest plane number for the current mode
	always_comb begin
		case (regs.shmode)
			shifter_pkg::MODE_MONO: last_plane = 2'd0;
			shifter_pkg::MODE_MID:  last_plane = 2'd1;
			default:                last_plane = 2'd3;
		endcase
	end

	// data arrives on the third edge after the strobe
	assign sample = rd_pipe[1];

	// ------------------------------------------------------------
	// read strobe, address counter and plane counter
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (cpu_reset) begin
			read <= 1'b0;
			rd_pipe <= '0;
			fetch_en_q <= 1'b0;
			plane_q <= '0;
			vaddr_q <= shifter_pkg::BASE_ADDR_RESET;
		end else begin
			// one word per 16 clocks inside the window
			read <= beam.fetch_en && (beam.word_phase == 4'd0);
			rd_pipe <= {rd_pipe[0], read};
			fetch_en_q <= beam.fetch_en;

			// every line starts at plane 0
			if (beam.fetch_en && !fetch_en_q)
				plane_q <= '0;
			else if (sample)
				plane_q <= (plane_q >= last_plane) ? 2'd0 : plane_q + 2'd1;

			// reload once per frame, step after each word taken
			if (beam.frame_reload)
				vaddr_q <= regs.base_addr;
			else if (sample)
				vaddr_q <= vaddr_q + 1'b1;
		end
	end

	// plane word latches
	always_ff @(posedge clk) begin
		if (sample)
			plane_words[plane_q] <= mem_data;
	end

	assign mem_addr = vaddr_q;
	assign regs.vaddr = vaddr_q;

	a_read_in_window: assert property (@(posedge clk) disable iff (cpu_reset)
		read |-> beam.fetch_en)
		else $error("memory read outside the fetch window");

endmodule

// ==== video_timing.sv ====
`timescale 1ns/1ps

module video_timing #(
	parameter int H_DISP   = shifter_pkg::DEF_H_DISP,
	parameter int H_BORDER = shifter_pkg::DEF_H_BORDER,
	parameter int H_BLANK  = shifter_pkg::DEF_H_BLANK,
	parameter int H_SYNC   = shifter_pkg::DEF_H_SYNC,
	parameter int V_DISP   = shifter_pkg::DEF_V_DISP,
	parameter int V_BORDER = shifter_pkg::DEF_V_BORDER,
	parameter int V_BLANK  = shifter_pkg::DEF_V_BLANK,
	parameter int V_SYNC   = shifter_pkg::DEF_V_SYNC
) (
	input  logic clk,
	input  logic cpu_reset,
	beam_if.timing beam,
	regs_if.timing regs,
	output logic hs,
	output logic vs
);

	// line order: display border blank sync blank border
	localparam int H_TOTAL = H_DISP + 2 * H_BORDER + 2 * H_BLANK + H_SYNC;
	localparam int V_TOTAL = V_DISP + 2 * V_BORDER + 2 * V_BLANK + V_SYNC;
	localparam int HW = $clog2(H_TOTAL);
	localparam int VW = $clog2(V_TOTAL);

	// region start points, display starts at count 0
	localparam int H_BLK_R = H_DISP + H_BORDER;
	localparam int H_SYN   = H_BLK_R + H_BLANK;
	localparam int H_BLK_L = H_SYN + H_SYNC;
	localparam int H_BRD_L = H_BLK_L + H_BLANK;
	localparam int V_BLK_B = V_DISP + V_BORDER;
	localparam int V_SYN   = V_BLK_B + V_BLANK;
	localparam int V_BLK_T = V_SYN + V_SYNC;
	localparam int V_BRD_T = V_BLK_T + V_BLANK;

	logic [HW-1:0] hcnt;
	logic [VW-1:0] vcnt;
	logic h_last, v_last;
	logic h_disp, h_blank, h_sync;
	logic v_disp, v_blank, v_sync, v_next_disp;
	logic [6:0] lead;
	logic fetch_on;

	// ------------------------------------------------------------
	// beam counters, one step per clk in every mode
	// ------------------------------------------------------------
	assign h_last = (hcnt == HW'(H_TOTAL - 1));
	assign v_last = (vcnt == VW'(V_TOTAL - 1));

	always_ff @(posedge clk) begin
		if (cpu_reset) begin
			hcnt <= '0;
			vcnt <= '0;
		end else begin
			hcnt <= h_last ? '0 : hcnt + 1'b1;
			// line changes on the last clock of the line
			if (h_last)
				vcnt <= v_last ? '0 : vcnt + 1'b1;
		end
	end

	// ------------------------------------------------------------
	// region decode
	// ------------------------------------------------------------
	always_comb begin
		h_disp = hcnt < H_DISP;
		// blank includes the sync part
		h_blank = (hcnt >= H_BLK_R) && (hcnt < H_BRD_L);
		h_sync = (hcnt >= H_SYN) && (hcnt < H_BLK_L);
		v_disp = vcnt < V_DISP;
		v_blank = (vcnt >= V_BLK_B) && (vcnt < V_BRD_T);
		v_sync = (vcnt >= V_SYN) && (vcnt < V_BLK_T);
		// next line shows display, the last top border line leads into line 0
		v_next_disp = v_last || (vcnt < V_DISP - 1);
		// prefetch lead is one group of 16 pixels in every mode
		case (regs.shmode)
			shifter_pkg::MODE_MONO: lead = 7'd16;
			shifter_pkg::MODE_MID:  lead = 7'd32;
			default:                lead = 7'd64;
		endcase
		// window runs from the end of the previous line into the display
		fetch_on = (v_disp && (hcnt < H_DISP - lead)) ||
			(v_next_disp && (hcnt >= H_TOTAL - lead));
	end

	// ------------------------------------------------------------
	// registered beam outputs, one cycle behind the counters
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (cpu_reset) begin
			beam.fetch_en <= 1'b0;
			beam.word_phase <= '0;
			beam.disp_start <= 1'b0;
			beam.in_display <= 1'b0;
			beam.blank <= 1'b1;
			beam.border <= 1'b0;
			beam.frame_reload <= 1'b0;
			hs <= 1'b1;
			vs <= 1'b1;
		end else begin
			beam.fetch_en <= fetch_on;
			beam.word_phase <= hcnt[3:0];
			beam.disp_start <= (hcnt == '0) && v_disp;
			beam.in_display <= h_disp && v_disp;
			beam.blank <= h_blank || v_blank;
			// visible but outside the display area
			beam.border <= !(h_blank || v_blank) && !(h_disp && v_disp);
			beam.frame_reload <= (hcnt == '0) && (vcnt == VW'(V_SYN));
			// sync pulses are active low
			hs <= !h_sync;
			vs <= !v_sync;
		end
	end

	// every fetch is followed by display within one group period,
	// so no fetch lands on a line without display
	a_fetch_leads_display: assert property (@(posedge clk) disable iff (cpu_reset)
		beam.fetch_en |-> ##[0:64] beam.in_display)
		else $error("fetch window outside a display line");

endmodule

// ==== shifter_regs.sv ====
`timescale 1ns/1ps

module shifter_regs (
	input  logic clk,
	input  logic cpu_reset,
	input  logic cpu_sel,
	input  logic cpu_rw,
	input  logic cpu_uds,
	input  logic cpu_lds,
	input  logic [5:0] cpu_addr,
	input  shifter_pkg::word_t cpu_din,
	output shifter_pkg::word_t cpu_dout,
	regs_if.regs regs
);

	// base address bits 22..7, the low seven bits stay zero
	// so a high or mid write leaves the low part cleared
	logic [15:0] base_q;
	shifter_pkg::shift_mode_e shmode_q;
	shifter_pkg::pal_entry_t [15:0] pal_q;

	logic wr;
	logic pal_sel;
	shifter_pkg::pal_entry_t rd_entry;

	assign wr = cpu_sel && !cpu_rw;
	assign pal_sel = (cpu_addr >= shifter_pkg::REG_PAL_FIRST) &&
		(cpu_addr <= shifter_pkg::REG_PAL_LAST);
	assign rd_entry = pal_q[cpu_addr[3:0]];

	// ------------------------------------------------------------
	// cpu write with active low byte lanes
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (cpu_reset) begin
			base_q <= shifter_pkg::BASE_ADDR_RESET[22:7];
			shmode_q <= shifter_pkg::DEFAULT_MODE;
			pal_q <= '0;
		end else if (wr) begin
			// base bytes sit in the low lane
			if (!cpu_lds && cpu_addr == shifter_pkg::REG_BASE_HI)
				base_q[15:8] <= cpu_din[7:0];
			if (!cpu_lds && cpu_addr == shifter_pkg::REG_BASE_MID)
				base_q[7:0] <= cpu_din[7:0];
			// shift mode sits in the high lane
			if (!cpu_uds && cpu_addr == shifter_pkg::REG_SHMODE)
				shmode_q <= shifter_pkg::shift_mode_e'(cpu_din[9:8]);
			if (pal_sel) begin
				// red in the upper byte, green and blue in the lower one
				if (!cpu_uds)
					pal_q[cpu_addr[3:0]].r <= cpu_din[10:8];
				if (!cpu_lds) begin
					pal_q[cpu_addr[3:0]].g <= cpu_din[6:4];
					pal_q[cpu_addr[3:0]].b <= cpu_din[2:0];
				end
			end
		end
	end

	// ------------------------------------------------------------
	// cpu read returns zero when not selected
	// ------------------------------------------------------------
	always_comb begin
		cpu_dout = '0;
		if (cpu_sel && cpu_rw) begin
			case (cpu_addr)
				shifter_pkg::REG_BASE_HI:   cpu_dout = {8'h00, base_q[15:8]};
				shifter_pkg::REG_BASE_MID:  cpu_dout = {8'h00, base_q[7:0]};
				shifter_pkg::REG_VADDR_HI:  cpu_dout = {8'h00, regs.vaddr[22:15]};
				shifter_pkg::REG_VADDR_MID: cpu_dout = {8'h00, regs.vaddr[14:7]};
				// low byte is a byte address with bit 0 always zero
				shifter_pkg::REG_VADDR_LO:  cpu_dout = {8'h00, regs.vaddr[6:0], 1'b0};
				shifter_pkg::REG_SHMODE:    cpu_dout = {6'h00, shmode_q, 8'h00};
				default: begin
					// msb of each st palette nibble reads as zero
					if (pal_sel)
						cpu_dout = {4'h0, 1'b0, rd_entry.r, 1'b0, rd_entry.g,
							1'b0, rd_entry.b};
				end
			endcase
		end
	end

	assign regs.base_addr = {base_q, 7'h00};
	assign regs.shmode = shmode_q;
	// lookup for the pixel path
	assign regs.pal_color = pal_q[regs.pal_index];

	// a write cycle carries a known address and at least one byte strobe
	a_write_lanes: assert property (@(posedge clk) disable iff (cpu_reset)
		wr |-> !$isunknown({cpu_addr, cpu_uds, cpu_lds}) && !(cpu_uds && cpu_lds))
		else $error("cpu write without a known address or byte strobe");

endmodule

// ==== regs_if.sv ====
`timescale 1ns/1ps

// register state shared between the register file and the video blocks
interface regs_if;

	// base address, low seven bits always zero
	shifter_pkg::vaddr_t base_addr;
	shifter_pkg::shift_mode_e shmode;
	// running video address, for cpu readback
	shifter_pkg::vaddr_t vaddr;

	// palette lookup port
	logic [3:0] pal_index;
	shifter_pkg::pal_entry_t pal_color;

	modport regs (
		output base_addr, shmode, pal_color,
		input vaddr, pal_index
	);

	modport fetch (
		input base_addr, shmode,
		output vaddr
	);

	modport timing (
		input shmode
	);

	modport pixel (
		input shmode, pal_color,
		output pal_index
	);

endinterface

// ==== beam_if.sv ====
`timescale 1ns/1ps

// beam position flags, all registered in the timing generator
interface beam_if;

	// prefetch window, leads display by one group period
	logic fetch_en;
	// position inside the 16 clock word period
	logic [3:0] word_phase;
	// first display clock of a display line
	logic disp_start;
	logic in_display;
	logic blank;
	logic border;
	// first clock of vsync, video counter reload
	logic frame_reload;

	modport timing (
		output fetch_en, word_phase, disp_start, in_display, blank, border, frame_reload
	);

	modport fetch (
		input fetch_en, word_phase, frame_reload
	);

	modport pixel (
		input disp_start, in_display, blank, border
	);

endinterface

// ==== shifter_pkg.sv ====
package shifter_pkg;

	// ------------------------------------------------------------
	// basic data types
	// ------------------------------------------------------------

	// memory and cpu register word
	typedef logic [15:0] word_t;
	// video word address, byte address bits 23..1
	typedef logic [22:0] vaddr_t;
	// one 3-bit palette channel
	typedef logic [2:0] color_t;

	typedef struct packed {
		color_t r;
		color_t g;
		color_t b;
	} pal_entry_t;

	// 4 bits per channel at the video pins
	typedef struct packed {
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
	} rgb_t;

	// shift mode register encoding, value 3 behaves like low rez
	typedef enum logic [1:0] {
		MODE_LOW  = 2'd0,
		MODE_MID  = 2'd1,
		MODE_MONO = 2'd2
	} shift_mode_e;

	localparam int MAX_PLANES = 4;

	// one latched word per bitplane
	typedef word_t [MAX_PLANES-1:0] plane_words_t;

	// ------------------------------------------------------------
	// reset values and register map
	// ------------------------------------------------------------

	// word address 0x8000 is byte address 0x010000
	localparam vaddr_t BASE_ADDR_RESET = 23'h008000;
	localparam shift_mode_e DEFAULT_MODE = MODE_MONO;

	localparam logic [5:0] REG_BASE_HI   = 6'h00;
	localparam logic [5:0] REG_BASE_MID  = 6'h01;
	localparam logic [5:0] REG_VADDR_HI  = 6'h02;
	localparam logic [5:0] REG_VADDR_MID = 6'h03;
	localparam logic [5:0] REG_VADDR_LO  = 6'h04;
	localparam logic [5:0] REG_PAL_FIRST = 6'h20;
	localparam logic [5:0] REG_PAL_LAST  = 6'h2f;
	localparam logic [5:0] REG_SHMODE    = 6'h30;

	// default beam geometry in clocks and lines
	// horizontal values are multiples of 64
	localparam int DEF_H_DISP   = 640;
	localparam int DEF_H_BORDER = 64;
	localparam int DEF_H_BLANK  = 64;
	localparam int DEF_H_SYNC   = 64;
	localparam int DEF_V_DISP   = 200;
	localparam int DEF_V_BORDER = 16;
	localparam int DEF_V_BLANK  = 8;
	localparam int DEF_V_SYNC   = 8;

endpackage
